//--- source/csr_pkg.sv
/*
 * Machine-mode CSR definitions
 * Shared addresses, write types, exception codes, register masks,
 * identity values, the decoded CSR index and the write-merge rule
 */

package csr_pkg;

	localparam int XLEN  = 32;        // Data word width
	localparam int N_IRQ = 16;        // External interrupt lines

	typedef logic [11:0] csr_addr_t;

	// ----------------------------------------
	// CSR addresses
	localparam csr_addr_t MSTATUS   = 12'h300;
	localparam csr_addr_t MISA      = 12'h301;
	localparam csr_addr_t MIE       = 12'h304;
	localparam csr_addr_t MTVEC     = 12'h305;
	localparam csr_addr_t MSCRATCH  = 12'h340;
	localparam csr_addr_t MEPC      = 12'h341;
	localparam csr_addr_t MCAUSE    = 12'h342;
	localparam csr_addr_t MTVAL     = 12'h343;
	localparam csr_addr_t MIP       = 12'h344;
	localparam csr_addr_t MVENDORID = 12'hf11;  // Identity block, read only
	localparam csr_addr_t MARCHID   = 12'hf12;
	localparam csr_addr_t MIMPID    = 12'hf13;
	localparam csr_addr_t MHARTID   = 12'hf14;
	localparam csr_addr_t MCYCLE    = 12'hb00;
	localparam csr_addr_t MTIME     = 12'hb01;  // Alias of mcycle
	localparam csr_addr_t MINSTRET  = 12'hb02;
	localparam csr_addr_t MCYCLEH   = 12'hb80;
	localparam csr_addr_t MTIMEH    = 12'hb81;  // Alias of mcycleh
	localparam csr_addr_t MINSTRETH = 12'hb82;

	// Write, set bits, clear bits
	typedef enum logic [1:0] {
		WTYPE_W = 2'h0,
		WTYPE_S = 2'h1,
		WTYPE_C = 2'h2
	} csr_wtype_t;

	// Exception code, 0 to 11 are the standard causes
	typedef logic [3:0] except_t;
	localparam except_t EXCEPT_NONE = 4'hf;
	localparam except_t EXCEPT_MRET = 4'he;  // Trap return, not a cause

	// One index per implemented register
	typedef enum logic [4:0] {
		ID_NONE, ID_MSTATUS, ID_MISA, ID_MIE, ID_MTVEC, ID_MSCRATCH,
		ID_MEPC, ID_MCAUSE, ID_MTVAL, ID_MIP, ID_MVENDORID, ID_MARCHID,
		ID_MIMPID, ID_MHARTID, ID_MCYCLE, ID_MINSTRET, ID_MCYCLEH, ID_MINSTRETH
	} csr_id_t;

	// ----------------------------------------
	// Field masks and constant values
	localparam logic [XLEN-1:0] MIE_CONST_MASK = 32'h0000f777;  // Tied-zero bits of mie
	localparam logic [XLEN-1:0] MTVEC_INIT     = 32'h00000001;  // Base 0, vectored mode
	localparam logic [XLEN-1:0] MTVEC_WMASK    = 32'hfffffffc;  // Mode field is fixed

	localparam logic [XLEN-1:0] MVENDORID_VAL = 32'h00000000;   // Non-commercial part
	localparam logic [XLEN-1:0] MARCHID_VAL   = 32'h0000001b;
	localparam logic [XLEN-1:0] MIMPID_VAL    = 32'h00010002;

	// New register value from old value, write data and write type
	function automatic logic [XLEN-1:0] csr_merge(
		input logic [XLEN-1:0] prev,
		input logic [XLEN-1:0] wdata,
		input csr_wtype_t      wtype
	);
		case (wtype)
			WTYPE_S: return prev | wdata;
			WTYPE_C: return prev & ~wdata;
			default: return wdata;        // Plain write
		endcase
	endfunction

endpackage

//--- source/csr_wr_if.sv
/*
 * Decoded CSR write bus
 * One legal write per cycle, from the access decoder to every
 * block that holds writeable state
 */

`timescale 1ns/1ps

interface csr_wr_if import csr_pkg::*; ();

	logic [XLEN-1:0] wdata;   // Write operand
	csr_wtype_t      wtype;   // Write, set or clear
	logic            wen;     // High only for legal writes
	csr_id_t         id;      // Target register index

	// Decoder side drives everything
	modport decoder (
		output wdata, wtype, wen, id
	);

	// Register holders only listen
	modport target (
		input wdata, wtype, wen, id
	);

endinterface

//--- source/perf_counter.sv
/*
 * 64-bit performance counter
 * Increments its low W_COUNTER bits on inc, with each 32-bit half
 * writeable through the CSR merge rule
 */

`timescale 1ns/1ps

module perf_counter import csr_pkg::*; #(
	parameter int W_COUNTER = 64
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            inc,     // Count enable
	input  logic            wr_lo,   // Write strobe, low word
	input  logic            wr_hi,   // Write strobe, high word
	input  logic [XLEN-1:0] wdata,
	input  csr_wtype_t      wtype,
	output logic [63:0]     value
);

	// Bits above W_COUNTER only change through writes
	localparam logic [63:0] INC_MASK = (W_COUNTER >= 64) ? {64{1'b1}} :
		~({64{1'b1}} << W_COUNTER);

	logic [63:0] bumped;

	assign bumped = ((value + 64'd1) & INC_MASK) | (value & ~INC_MASK);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			value <= '0;
		end else begin
			// Low half, a write wins over the count
			if (wr_lo)
				value[XLEN-1:0] <= csr_merge(value[XLEN-1:0], wdata, wtype);
			else if (inc)
				value[XLEN-1:0] <= bumped[XLEN-1:0];
			// High half, same rule
			if (wr_hi)
				value[2*XLEN-1:XLEN] <= csr_merge(value[2*XLEN-1:XLEN], wdata, wtype);
			else if (inc)
				value[2*XLEN-1:XLEN] <= bumped[2*XLEN-1:XLEN];
		end
	end

endmodule

//--- source/trap_state.sv
/*
 * Trap-handling registers
 * mstatus interrupt stack, mscratch, mtvec, mepc, mie, mcause and the
 * registered interrupt pending word. Updated by software writes and
 * by trap entry and mret, which take priority over a write
 */

`timescale 1ns/1ps

module trap_state import csr_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	csr_wr_if.target         wr,
	input  logic             trap_take,    // Trap handshake completes this edge
	input  except_t          except,
	input  logic [XLEN-1:0]  mepc_in,
	input  logic [XLEN-1:0]  mcause_next,
	input  logic [N_IRQ-1:0] irq,
	output logic             mstatus_mie,
	output logic             mstatus_mpie,
	output logic [XLEN-1:0]  mtvec,
	output logic [XLEN-1:0]  mepc,
	output logic [XLEN-1:0]  mscratch,
	output logic [XLEN-1:0]  mie,
	output logic [XLEN-1:0]  mip,
	output logic [XLEN-1:0]  mcause
);

	localparam logic [XLEN-1:0] MEPC_MASK = {{XLEN-1{1'b1}}, 1'b0};  // Halfword aligned

	logic            is_mret, enter;
	logic [XLEN-1:0] mstatus_new, mcause_new;
	logic [N_IRQ-1:0] irq_q;
	logic            mcause_irq;
	logic [4:0]      mcause_code;

	assign is_mret = trap_take && except == EXCEPT_MRET;
	assign enter   = trap_take && except != EXCEPT_MRET;

	// Merge against the architectural view so set and clear hit the right bits
	assign mstatus_new = csr_merge({24'h0, mstatus_mpie, 3'h0, mstatus_mie, 3'h0},
		wr.wdata, wr.wtype);
	assign mcause_new  = csr_merge(mcause, wr.wdata, wr.wtype);

	// ----------------------------------------
	// Interrupt enable stack
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mstatus_mie  <= 1'b0;
			mstatus_mpie <= 1'b0;
		end else if (is_mret) begin
			mstatus_mie  <= mstatus_mpie;   // Restore
			mstatus_mpie <= 1'b1;
		end else if (enter) begin
			mstatus_mpie <= mstatus_mie;    // Push and disable
			mstatus_mie  <= 1'b0;
		end else if (wr.wen && wr.id == ID_MSTATUS) begin
			mstatus_mpie <= mstatus_new[7];
			mstatus_mie  <= mstatus_new[3];
		end
	end

	// ----------------------------------------
	// Software-owned registers and trap save state
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mscratch    <= '0;
			mtvec       <= MTVEC_INIT;
			mepc        <= '0;
			mie         <= '0;
			mcause_irq  <= 1'b0;
			mcause_code <= '0;
		end else begin
			if (wr.wen && wr.id == ID_MSCRATCH)
				mscratch <= csr_merge(mscratch, wr.wdata, wr.wtype);
			if (wr.wen && wr.id == ID_MTVEC)   // Mode bits stay vectored
				mtvec <= (csr_merge(mtvec, wr.wdata, wr.wtype) & MTVEC_WMASK) |
					(MTVEC_INIT & ~MTVEC_WMASK);
			if (wr.wen && wr.id == ID_MIE)
				mie <= csr_merge(mie, wr.wdata, wr.wtype) & ~MIE_CONST_MASK;
			if (enter) begin
				mepc        <= mepc_in & MEPC_MASK;
				mcause_irq  <= mcause_next[XLEN-1];
				mcause_code <= mcause_next[4:0];
			end else begin
				if (wr.wen && wr.id == ID_MEPC)
					mepc <= csr_merge(mepc, wr.wdata, wr.wtype) & MEPC_MASK;
				if (wr.wen && wr.id == ID_MCAUSE) begin
					mcause_irq  <= mcause_new[XLEN-1];
					mcause_code <= mcause_new[4:0];
				end
			end
		end
	end

	assign mcause = {mcause_irq, {XLEN-6{1'b0}}, mcause_code};

	// ----------------------------------------
	// Pending word, one register stage on the irq lines
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			irq_q <= '0;
		else
			irq_q <= irq;
	end

	// Per-irq bits up top, global external pending in bit 11
	assign mip = {irq_q, 4'h0, |irq_q, 11'h0};

endmodule

//--- source/trap_request.sv
/*
 * Trap request generation
 * Masks pending interrupts, picks the winning one, forms the vectored
 * trap address and the next mcause, and raises trap_enter_vld
 */

`timescale 1ns/1ps

module trap_request import csr_pkg::*; (
	input  except_t         except,
	input  logic [XLEN-1:0] mip,
	input  logic [XLEN-1:0] mie,
	input  logic            mstatus_mie,
	input  logic            delay_irq_entry,
	input  logic [XLEN-1:0] mtvec,
	input  logic [XLEN-1:0] mepc,
	output logic [XLEN-1:0] trap_addr,
	output logic            trap_is_irq,
	output logic            trap_enter_vld,
	output logic [XLEN-1:0] mcause_next
);

	logic            exc_any, irq_any;
	logic [XLEN-1:0] irq_masked;
	logic [4:0]      irq_num;
	logic [11:0]     vec_offs;
	logic [XLEN-1:0] mtvec_base;

	assign exc_any = except != EXCEPT_NONE;   // mret counts here too

	// Global pending bit is informational only, per-irq bits also need meie
	assign irq_masked = mip & mie & ~32'h0000_0800 & {{N_IRQ{mie[11]}}, {XLEN-N_IRQ{1'b1}}};
	assign irq_any    = |irq_masked && mstatus_mie && !delay_irq_entry;

	// ----------------------------------------
	// Lowest-numbered pending bit wins
	always_comb begin
		irq_num = '0;
		for (int i = XLEN - 1; i >= 0; i--) begin
			if (irq_masked[i])
				irq_num = 5'(i);
		end
	end

	// Vector slot, exceptions first then 16 plus the mip bit
	assign vec_offs   = exc_any ? {6'h0, except, 2'b00} : {4'h0, 6'd16 + irq_num, 2'b00};
	assign mtvec_base = {mtvec[XLEN-1:2], 2'b00};   // Drop the mode field

	assign trap_addr      = (except == EXCEPT_MRET) ? mepc :
		mtvec_base + {{XLEN-12{1'b0}}, vec_offs};
	assign trap_is_irq    = !exc_any;
	assign trap_enter_vld = exc_any || irq_any;

	// Cause word as mcause will hold it
	assign mcause_next = exc_any ? {1'b0, {XLEN-6{1'b0}}, 1'b0, except} :
		{1'b1, {XLEN-6{1'b0}}, irq_num};

endmodule

//--- source/csr_read_mux.sv
/*
 * CSR read multiplexer
 * Builds the read word for the decoded index, including the fixed
 * fields of mstatus and misa and the identity constants
 */

`timescale 1ns/1ps

module csr_read_mux import csr_pkg::*; (
	input  csr_id_t         id,
	input  logic            mstatus_mie,
	input  logic            mstatus_mpie,
	input  logic [XLEN-1:0] mtvec,
	input  logic [XLEN-1:0] mepc,
	input  logic [XLEN-1:0] mscratch,
	input  logic [XLEN-1:0] mie,
	input  logic [XLEN-1:0] mip,
	input  logic [XLEN-1:0] mcause,
	input  logic [63:0]     cycle,
	input  logic [63:0]     instret,
	output logic [XLEN-1:0] rdata
);

	logic [XLEN-1:0] mstatus_rd, misa_rd;

	// ----------------------------------------
	// Fixed-layout registers
	assign mstatus_rd = {
		19'h0,           // No S or U state, no extension state
		2'b11,           // MPP, always M-mode
		3'h0,
		mstatus_mpie,
		3'h0,
		mstatus_mie,
		3'h0
	};

	assign misa_rd = {
		2'h1,            // MXL 32-bit
		4'h0,
		13'h0,           // Z to N
		1'b1,            // M
		3'h0,            // L to J
		1'b1,            // I, base integer ISA
		5'h0,            // H to D
		1'b0,            // C
		2'h0             // B, A
	};

	always_comb begin
		case (id)
			ID_MSTATUS:   rdata = mstatus_rd;
			ID_MISA:      rdata = misa_rd;
			ID_MIE:       rdata = mie;
			ID_MTVEC:     rdata = mtvec;
			ID_MSCRATCH:  rdata = mscratch;
			ID_MEPC:      rdata = mepc;
			ID_MCAUSE:    rdata = {mcause[XLEN-1], {XLEN-6{1'b0}}, mcause[4:0]};  // IRQ flag, code
			ID_MIP:       rdata = mip;
			ID_MVENDORID: rdata = MVENDORID_VAL;
			ID_MARCHID:   rdata = MARCHID_VAL;
			ID_MIMPID:    rdata = MIMPID_VAL;
			ID_MHARTID:   rdata = '0;                      // Single hart
			ID_MCYCLE:    rdata = cycle[XLEN-1:0];
			ID_MCYCLEH:   rdata = cycle[2*XLEN-1:XLEN];
			ID_MINSTRET:  rdata = instret[XLEN-1:0];
			ID_MINSTRETH: rdata = instret[2*XLEN-1:XLEN];
			default:      rdata = '0;                      // mtval and unmapped
		endcase
	end

endmodule

//--- source/csr_access_decode.sv
/*
 * CSR access decoder
 * Maps the address onto a register index, flags unmapped and
 * read-only accesses, and puts legal writes on the write bus
 */

`timescale 1ns/1ps

module csr_access_decode import csr_pkg::*; (
	input  csr_addr_t       addr,
	input  logic [XLEN-1:0] wdata,
	input  csr_wtype_t      wtype,
	input  logic            wen,
	input  logic            ren,
	output csr_id_t         id,
	output logic            illegal,
	csr_wr_if.decoder       wr
);

	logic read_only;   // Register exists but refuses writes

	// ----------------------------------------
	// Address map, the only address compare in the design
	always_comb begin
		read_only = 1'b0;
		case (addr)
			MSTATUS:   id = ID_MSTATUS;
			MISA:      begin id = ID_MISA;      read_only = 1'b1; end
			MIE:       id = ID_MIE;
			MTVEC:     id = ID_MTVEC;
			MSCRATCH:  id = ID_MSCRATCH;
			MEPC:      id = ID_MEPC;
			MCAUSE:    id = ID_MCAUSE;
			MTVAL:     begin id = ID_MTVAL;     read_only = 1'b1; end  // Hardwired zero
			MIP:       id = ID_MIP;                                     // Writes have no effect
			MVENDORID: begin id = ID_MVENDORID; read_only = 1'b1; end
			MARCHID:   begin id = ID_MARCHID;   read_only = 1'b1; end
			MIMPID:    begin id = ID_MIMPID;    read_only = 1'b1; end
			MHARTID:   begin id = ID_MHARTID;   read_only = 1'b1; end
			MCYCLE,
			MTIME:     id = ID_MCYCLE;                                  // Time aliases cycle
			MINSTRET:  id = ID_MINSTRET;
			MCYCLEH,
			MTIMEH:    id = ID_MCYCLEH;
			MINSTRETH: id = ID_MINSTRETH;
			default:   id = ID_NONE;
		endcase
	end

	// Unmapped access, or a write to something read only
	assign illegal = ((wen || ren) && id == ID_NONE) || (wen && read_only);

	// ----------------------------------------
	// Write bus, gated so targets never see an illegal write
	assign wr.wen   = wen && !illegal;
	assign wr.id    = id;
	assign wr.wdata = wdata;
	assign wr.wtype = wtype;

endmodule

//--- source/csr_block.sv
/*
 * Machine-mode CSR block
 * Ties together the access decoder, trap registers, trap request
 * logic, the mcycle and minstret counters and the read multiplexer
 */

`timescale 1ns/1ps

module csr_block import csr_pkg::*; #(
	parameter int W_COUNTER = 64               // Counter bits incremented in hardware
) (
	input  logic             clk,
	input  logic             rst_n,
	// CSR access port, reads combinational
	input  csr_addr_t        addr,
	input  logic [XLEN-1:0]  wdata,
	input  logic             wen,
	input  logic             ren,
	input  csr_wtype_t       wtype,
	output logic [XLEN-1:0]  rdata,
	output logic             illegal,
	// Trap handshake
	output logic [XLEN-1:0]  trap_addr,
	output logic             trap_is_irq,
	output logic             trap_enter_vld,
	input  logic             trap_enter_rdy,
	input  logic [XLEN-1:0]  mepc_in,
	input  logic             delay_irq_entry,
	input  logic [N_IRQ-1:0] irq,
	input  except_t          except,
	input  logic             instr_ret
);

	// ----------------------------------------
	// Internal wiring
	csr_wr_if wr_bus ();

	csr_id_t         rd_id;
	logic            st_mie, st_mpie;
	logic [XLEN-1:0] mtvec, mepc, mscratch, mie, mip, mcause;
	logic [XLEN-1:0] mcause_next;
	logic            trap_take;
	logic [1:0]      ctr_inc;
	logic [63:0]     ctr_value [2];

	// Counter 0 is mcycle, counter 1 is minstret
	localparam csr_id_t CTR_LO_ID [2] = '{ID_MCYCLE, ID_MINSTRET};
	localparam csr_id_t CTR_HI_ID [2] = '{ID_MCYCLEH, ID_MINSTRETH};

	assign trap_take = trap_enter_vld && trap_enter_rdy;  // Handshake edge
	assign ctr_inc   = {instr_ret, 1'b1};                 // mcycle always counts

	csr_access_decode u_decode (
		.addr(addr), .wdata(wdata), .wtype(wtype), .wen(wen), .ren(ren),
		.id(rd_id), .illegal(illegal), .wr(wr_bus.decoder)
	);

	trap_state u_state (
		.clk(clk), .rst_n(rst_n), .wr(wr_bus.target),
		.trap_take(trap_take), .except(except), .mepc_in(mepc_in),
		.mcause_next(mcause_next), .irq(irq),
		.mstatus_mie(st_mie), .mstatus_mpie(st_mpie), .mtvec(mtvec), .mepc(mepc),
		.mscratch(mscratch), .mie(mie), .mip(mip), .mcause(mcause)
	);

	trap_request u_request (
		.except(except), .mip(mip), .mie(mie), .mstatus_mie(st_mie),
		.delay_irq_entry(delay_irq_entry), .mtvec(mtvec), .mepc(mepc),
		.trap_addr(trap_addr), .trap_is_irq(trap_is_irq),
		.trap_enter_vld(trap_enter_vld), .mcause_next(mcause_next)
	);

	// Write strobes per counter half come straight from the write bus
	for (genvar i = 0; i < 2; i++) begin : g_ctr
		perf_counter #(.W_COUNTER(W_COUNTER)) u_ctr (
			.clk(clk), .rst_n(rst_n), .inc(ctr_inc[i]),
			.wr_lo(wr_bus.wen && wr_bus.id == CTR_LO_ID[i]),
			.wr_hi(wr_bus.wen && wr_bus.id == CTR_HI_ID[i]),
			.wdata(wr_bus.wdata), .wtype(wr_bus.wtype), .value(ctr_value[i])
		);
	end

	csr_read_mux u_rd_mux (
		.id(rd_id), .mstatus_mie(st_mie), .mstatus_mpie(st_mpie),
		.mtvec(mtvec), .mepc(mepc), .mscratch(mscratch), .mie(mie), .mip(mip),
		.mcause(mcause), .cycle(ctr_value[0]), .instret(ctr_value[1]), .rdata(rdata)
	);

endmodule

//--- bench/csr_block_tb.sv
/*
 * Testbench for the machine-mode CSR block
 * Reference model for merge, trap address and the mstatus stack,
 * LFSR stimulus, per-test reporting and a watchdog
 */

`timescale 1ns/1ps

module csr_block_tb import csr_pkg::*; ();

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 3;
	localparam int VLD_TIMEOUT  = 8;     // Cycles allowed for a trap request to rise
	// Rough per-test budgets, in cycles
	localparam int TEST_CYCLES  = 20 + 40 + 50 + 40 + 50 + 30;
	localparam int MARGIN       = 100;

	logic             clk = 1'b0;
	logic             rst_n;
	csr_addr_t        addr;
	logic [XLEN-1:0]  wdata;
	logic             wen;
	logic             ren;
	csr_wtype_t       wtype;
	logic [XLEN-1:0]  rdata;
	logic             illegal;
	logic [XLEN-1:0]  trap_addr;
	logic             trap_is_irq;
	logic             trap_enter_vld;
	logic             trap_enter_rdy;
	logic [XLEN-1:0]  mepc_in;
	logic             delay_irq_entry;
	logic [N_IRQ-1:0] irq;
	except_t          except;
	logic             instr_ret;

	logic [31:0] lfsr = 32'h7012;        // Stimulus state
	int          errors, test_errs, checks, tests;

	csr_addr_t mapped_list [0:18] = '{
		MSTATUS, MISA, MIE, MTVEC, MSCRATCH, MEPC, MCAUSE, MTVAL, MIP, MVENDORID,
		MARCHID, MIMPID, MHARTID, MCYCLE, MTIME, MINSTRET, MCYCLEH, MTIMEH, MINSTRETH
	};
	csr_addr_t unmapped_list [0:3] = '{12'hb03, 12'h320, 12'h323, 12'h7c0};  // hpm, inhibit
	csr_addr_t ro_list [0:5] = '{MISA, MVENDORID, MARCHID, MIMPID, MHARTID, MTVAL};

	csr_block #(.W_COUNTER(64)) dut0 (.*);

	initial begin
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ----------------------------------------
	// Reference model

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [31:0] merge_word(input logic [31:0] prev, input logic [31:0] d,
		input csr_wtype_t wt);
		if (wt == WTYPE_S)
			return prev | d;
		if (wt == WTYPE_C)
			return prev & ~d;
		return d;
	endfunction

	// Read view of mstatus from {mpie, mie}, MPP fixed at M
	function automatic logic [31:0] mstatus_view(input logic [1:0] st);
		return {19'h0, 2'b11, 3'h0, st[1], 3'h0, st[0], 3'h0};
	endfunction

	// Interrupt enable stack after trap entry or mret
	function automatic logic [1:0] stack_after(input bit is_mret, input logic [1:0] st);
		if (is_mret)
			return {1'b1, st[1]};
		return {st[0], 1'b0};
	endfunction

	function automatic logic [31:0] trap_vector(input except_t code, input int irq_bit,
		input logic [31:0] mtvec, input logic [31:0] mepc);
		logic [31:0] base;
		int          slot;
		base = {mtvec[31:2], 2'b00};
		if (code == EXCEPT_MRET)
			return mepc;
		if (code != EXCEPT_NONE)
			return base + 4 * code;
		slot = 16 + irq_bit;
		return base + 4 * slot;
	endfunction

	// ----------------------------------------
	// Bus tasks, entered and left at a falling edge

	task automatic check_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errs++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic access(input csr_addr_t a, input logic [31:0] d, input csr_wtype_t wt,
		input logic we, output logic [31:0] rd, output logic ill);
		addr  = a;
		wdata = d;
		wtype = wt;
		wen   = we;
		ren   = !we;
		#1;                              // Combinational read path settles
		rd  = rdata;
		ill = illegal;
		@(negedge clk);
		wen = 1'b0;
		ren = 1'b0;
	endtask

	task automatic write_reg(input csr_addr_t a, input logic [31:0] d, input csr_wtype_t wt);
		logic [31:0] rd;
		logic        ill;
		access(a, d, wt, 1'b1, rd, ill);
		check_word("illegal", ill, 0);
	endtask

	task automatic read_reg(input csr_addr_t a, output logic [31:0] rd);
		logic ill;
		access(a, '0, WTYPE_W, 1'b0, rd, ill);
		check_word("illegal", ill, 0);
	endtask

	// Polls a little after each falling edge, ends there when found
	task automatic wait_for_vld();
		bit seen;
		seen = 1'b0;
		for (int i = 0; i < VLD_TIMEOUT && !seen; i++) begin
			#1;
			seen = trap_enter_vld;
			if (!seen)
				@(negedge clk);
		end
		if (!seen) begin
			errors++;
			test_errs++;
			$display("Trap request never rose within %0d cycles", VLD_TIMEOUT);
		end
	endtask

	task automatic expect_no_request(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			#1;
			check_word("trap_enter_vld", trap_enter_vld, 0);
			@(negedge clk);
		end
	endtask

	// Accept the pending request on the next rising edge
	task automatic handshake(input logic [31:0] pc);
		@(negedge clk);
		trap_enter_rdy = 1'b1;
		mepc_in        = pc;
		@(negedge clk);
		trap_enter_rdy = 1'b0;
		except         = EXCEPT_NONE;
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (test_errs == 0)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: %0d errors", tests, name, test_errs);
		test_errs = 0;
	endtask

	// ----------------------------------------
	// Stimulus and checks
	initial begin
		logic [31:0] d, v, rd, pc, m_mscratch, m_mtvec, m_mepc;
		logic [63:0] cnt;
		logic [1:0]  m_st;                // {mpie, mie}
		logic        ill;
		int          k, n, code, hold;

		errors = 0;
		test_errs = 0;
		checks = 0;
		tests = 0;
		rst_n = 1'b0;
		addr = '0;
		wdata = '0;
		wen = 1'b0;
		ren = 1'b0;
		wtype = WTYPE_W;
		trap_enter_rdy = 1'b0;
		mepc_in = '0;
		delay_irq_entry = 1'b0;
		irq = '0;
		except = EXCEPT_NONE;
		instr_ret = 1'b0;
		m_mscratch = '0;
		m_mepc = '0;
		m_st = 2'b00;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;

		// Write, set and clear in turn
		for (int i = 0; i < 6; i++) begin
			d = rand_bits(32);
			write_reg(MSCRATCH, d, csr_wtype_t'(i % 3));
			m_mscratch = merge_word(m_mscratch, d, csr_wtype_t'(i % 3));
			read_reg(MSCRATCH, rd);
			check_word("rdata mscratch", rd, m_mscratch);
		end
		finish_test("mscratch write types");

		for (int i = 0; i < 19; i++)
			read_reg(mapped_list[i], rd);
		for (int i = 0; i < 4; i++) begin
			access(unmapped_list[i], '0, WTYPE_W, 1'b0, rd, ill);
			check_word("illegal", ill, 1);
			check_word("rdata unmapped", rd, 0);
		end
		for (int i = 0; i < 6; i++) begin
			access(ro_list[i], rand_bits(32), WTYPE_W, 1'b1, rd, ill);
			check_word("illegal", ill, 1);
		end
		read_reg(MVENDORID, rd);
		check_word("rdata mvendorid", rd, MVENDORID_VAL);
		read_reg(MSTATUS, rd);
		check_word("rdata mstatus", rd, mstatus_view(m_st));
		finish_test("legality and constants");

		// mcycle keeps counting after the write edge
		v = rand_bits(32);
		k = 1 + rand_bits(4);
		write_reg(MCYCLE, v, WTYPE_W);
		repeat (k) @(negedge clk);
		read_reg(MCYCLE, rd);
		check_word("rdata mcycle", rd, v + k);
		read_reg(MTIME, rd);             // One more edge has passed
		check_word("rdata mtime", rd, v + k + 1);
		v = rand_bits(32);
		n = 1 + rand_bits(3);
		write_reg(MINSTRET, v, WTYPE_W);
		for (int i = 0; i < n; i++) begin
			instr_ret = 1'b1;
			@(negedge clk);
			instr_ret = 1'b0;
			repeat (rand_bits(1)) @(negedge clk);  // Uneven gaps
		end
		cnt = {32'h0, v} + n;
		read_reg(MINSTRET, rd);
		check_word("rdata minstret", rd, cnt[31:0]);
		read_reg(MINSTRETH, rd);
		check_word("rdata minstreth", rd, cnt[63:32]);
		finish_test("counters");

		d = rand_bits(32);
		write_reg(MTVEC, d, WTYPE_W);
		m_mtvec = (d & 32'hffff_fffc) | 32'h1;   // Mode stays vectored
		read_reg(MTVEC, rd);
		check_word("rdata mtvec", rd, m_mtvec);
		write_reg(MSTATUS, 32'h8, WTYPE_S);
		d = merge_word(mstatus_view(m_st), 32'h8, WTYPE_S);
		m_st = {d[7], d[3]};
		code = rand_bits(4) % 12;
		hold = 1 + rand_bits(2);
		except = except_t'(code);
		wait_for_vld();
		check_word("trap_addr", trap_addr, trap_vector(except_t'(code), 0, m_mtvec, m_mepc));
		check_word("trap_is_irq", trap_is_irq, 0);
		for (int i = 0; i < hold; i++) begin   // Back-pressure, request must hold
			@(negedge clk);
			#1;
			check_word("trap_enter_vld", trap_enter_vld, 1);
			check_word("trap_addr", trap_addr, trap_vector(except_t'(code), 0, m_mtvec, m_mepc));
		end
		pc = rand_bits(32);
		handshake(pc);
		m_mepc = pc & 32'hffff_fffe;
		m_st = stack_after(1'b0, m_st);
		read_reg(MEPC, rd);
		check_word("rdata mepc", rd, m_mepc);
		read_reg(MCAUSE, rd);
		check_word("rdata mcause", rd, code);
		read_reg(MSTATUS, rd);
		check_word("rdata mstatus", rd, mstatus_view(m_st));
		finish_test("exception trap");

		k = rand_bits(4);
		write_reg(MSTATUS, 32'h8, WTYPE_S);
		d = merge_word(mstatus_view(m_st), 32'h8, WTYPE_S);
		m_st = {d[7], d[3]};
		write_reg(MIE, 32'h1 << (16 + k), WTYPE_W);
		irq = 16'h1 << k;
		expect_no_request(3);            // meie still clear
		delay_irq_entry = 1'b1;
		write_reg(MIE, 32'h800, WTYPE_S);
		expect_no_request(3);            // Entry held off
		delay_irq_entry = 1'b0;
		wait_for_vld();
		check_word("trap_addr", trap_addr, trap_vector(EXCEPT_NONE, 16 + k, m_mtvec, m_mepc));
		check_word("trap_is_irq", trap_is_irq, 1);
		pc = rand_bits(32);
		handshake(pc);
		irq = '0;
		m_mepc = pc & 32'hffff_fffe;
		m_st = stack_after(1'b0, m_st);
		read_reg(MCAUSE, rd);
		check_word("rdata mcause", rd, 32'h8000_0000 | (16 + k));
		read_reg(MEPC, rd);
		check_word("rdata mepc", rd, m_mepc);
		read_reg(MSTATUS, rd);
		check_word("rdata mstatus", rd, mstatus_view(m_st));
		finish_test("interrupt trap");

		// Random MPIE, MIE clear
		d = rand_bits(1) << 7;
		write_reg(MSTATUS, d, WTYPE_W);
		m_st = {d[7], d[3]};
		read_reg(MSTATUS, rd);
		check_word("rdata mstatus", rd, mstatus_view(m_st));
		except = EXCEPT_MRET;
		wait_for_vld();
		check_word("trap_addr", trap_addr, trap_vector(EXCEPT_MRET, 0, m_mtvec, m_mepc));
		check_word("trap_is_irq", trap_is_irq, 0);
		handshake(rand_bits(32));
		m_st = stack_after(1'b1, m_st);
		read_reg(MSTATUS, rd);
		check_word("rdata mstatus", rd, mstatus_view(m_st));
		read_reg(MEPC, rd);
		check_word("rdata mepc", rd, m_mepc);
		finish_test("mret");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// ----------------------------------------
	// Watchdog
	initial begin
		#((RESET_CYCLES + TEST_CYCLES + MARGIN) * CLK_PERIOD);
		$display("Watchdog expired before the tests completed");
		$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- compile.f
source/csr_pkg.sv
source/csr_wr_if.sv
source/perf_counter.sv
source/trap_state.sv
source/trap_request.sv
source/csr_read_mux.sv
source/csr_access_decode.sv
source/csr_block.sv
bench/csr_block_tb.sv

//--- Bender.yml
package:
  name: csr_block

sources:
  - files:
      - source/csr_pkg.sv
      - source/csr_wr_if.sv
      - source/perf_counter.sv
      - source/trap_state.sv
      - source/trap_request.sv
      - source/csr_read_mux.sv
      - source/csr_access_decode.sv
      - source/csr_block.sv
  - target: simulation
    files:
      - bench/csr_block_tb.sv
